// File: debug_pkg.sv
`default_nettype none

package debug_pkg;

  ////////////////////
  // Widths.
  localparam int BYTE_WIDTH      = 8;
  localparam int INSTR_WIDTH     = 32;
  localparam int BYTES_PER_INSTR = 4;   // Link bytes per instruction word.
  localparam int MEM_ADDR_WIDTH  = 11;
  localparam int PC_WIDTH        = 16;
  localparam int CYCLE_WIDTH     = 16;
  localparam int REPORT_BYTES    = 8;   // PC, cycle count, instruction.

  ////////////////////
  // Types.
  typedef logic [BYTE_WIDTH-1:0]                byte_t;
  typedef logic [INSTR_WIDTH-1:0]               instr_t;
  typedef logic [$clog2(BYTES_PER_INSTR)-1:0]   byte_count_t;
  typedef logic [MEM_ADDR_WIDTH-1:0]            mem_addr_t;
  typedef logic [PC_WIDTH-1:0]                  pc_t;
  typedef logic [CYCLE_WIDTH-1:0]               cycle_t;
  typedef logic [$clog2(REPORT_BYTES)-1:0]      report_index_t;

  // Ends a continuous run and also terminates a program load.
  localparam instr_t HALT_WORD = '0;

  ////////////////////
  // Host protocol.
  localparam byte_t CMD_LOAD    = 8'h00;  // Request soft reset and load.
  localparam byte_t CMD_LOAD_GO = 8'h01;  // Program bytes follow.
  localparam byte_t CMD_RUN     = 8'h03;  // Run until HALT.
  localparam byte_t CMD_STEP    = 8'h07;  // Run a single cycle.
  localparam byte_t ACK_LOAD    = 8'h01;  // Soft reset done.

  typedef enum logic [2:0] {
    S_IDLE,
    S_SOFT_RESET,
    S_SEND_ACK,
    S_WAIT_GO,
    S_LOAD,
    S_WAIT_START,
    S_RUN,
    S_REPORT
  } seq_state_t;

endpackage

`default_nettype wire

// File: program_loader.sv
`timescale 1ns/1ps
`default_nettype none

module program_loader (
  input  logic                 i_clock,
  input  logic                 i_reset,
  input  logic                 i_byte_valid,
  input  debug_pkg::byte_t     i_byte,
  input  logic                 i_clear,
  output logic                 o_done,
  output logic                 o_mem_write,
  output debug_pkg::mem_addr_t o_mem_addr,
  output debug_pkg::instr_t    o_mem_data
);

  import debug_pkg::*;

  instr_t      shift_word;     // Bytes of the word in progress.
  instr_t      next_word;
  byte_count_t byte_count;
  logic        word_complete;
  logic        word_is_halt;

  // Most significant byte arrives first, so shift in from the bottom.
  assign next_word     = {shift_word[INSTR_WIDTH-BYTE_WIDTH-1:0], i_byte};
  assign word_complete = i_byte_valid &&
                         (byte_count == byte_count_t'(BYTES_PER_INSTR - 1));
  assign word_is_halt  = (next_word == HALT_WORD);

  ////////////////////
  // Word assembly.
  always_ff @(posedge i_clock) begin
    if (i_byte_valid) begin
      shift_word <= next_word;
    end
    if (word_complete) begin
      o_mem_data <= next_word;  // Held for the write pulse.
    end
  end

  ////////////////////
  // Counters and strobes.
  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      byte_count  <= '0;
      o_mem_addr  <= '0;
      o_mem_write <= 1'b0;
      o_done      <= 1'b0;
    end else begin
      o_mem_write <= word_complete && !word_is_halt;
      o_done      <= word_complete && word_is_halt;  // End of program.
      if (i_clear) begin
        byte_count <= '0;
        o_mem_addr <= '0;
      end else begin
        if (i_byte_valid) begin
          byte_count <= byte_count + byte_count_t'(1);  // Wraps per word.
        end
        // Address moves on once the write has been issued.
        if (o_mem_write) begin
          o_mem_addr <= o_mem_addr + mem_addr_t'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: run_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module run_monitor (
  input  logic              i_clock,
  input  logic              i_reset,
  input  logic              i_start,
  input  logic              i_step,
  input  logic              i_clear,
  input  debug_pkg::pc_t    i_pc,
  input  debug_pkg::instr_t i_instruction,
  output logic              o_pc_enable,
  output logic              o_stopped,
  output logic              o_halted,
  output debug_pkg::pc_t    o_snap_pc,
  output debug_pkg::cycle_t o_snap_cycles,
  output debug_pkg::instr_t o_snap_instr
);

  import debug_pkg::*;

  logic   running;
  logic   step_mode;    // Stop after one enabled cycle.
  logic   at_halt;
  logic   stop;
  cycle_t cycle_count;

  assign at_halt     = (i_instruction == HALT_WORD);
  assign o_pc_enable = running && !at_halt;
  // In step mode the first cycle always ends the run.
  assign stop        = running && (at_halt || step_mode);

  ////////////////////
  // Run control.
  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      running     <= 1'b0;
      step_mode   <= 1'b0;
      o_stopped   <= 1'b0;
      o_halted    <= 1'b0;
      cycle_count <= '0;
    end else begin
      o_stopped <= stop;
      if (i_start) begin
        running   <= 1'b1;
        step_mode <= i_step;
      end else if (stop) begin
        running <= 1'b0;
      end
      if (stop) begin
        o_halted <= at_halt;  // Remember why we stopped.
      end
      if (i_clear) begin
        cycle_count <= '0;
      end else if (o_pc_enable) begin
        cycle_count <= cycle_count + cycle_t'(1);
      end
    end
  end

  // The PC has advanced by the time o_stopped is high.
  always_ff @(posedge i_clock) begin
    if (o_stopped) begin
      o_snap_pc     <= i_pc;
      o_snap_cycles <= cycle_count;
      o_snap_instr  <= i_instruction;
    end
  end

endmodule

`default_nettype wire

// File: link_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

module link_transmitter (
  input  logic              i_clock,
  input  logic              i_reset,
  input  logic              i_send_ack,
  input  logic              i_send_report,
  input  debug_pkg::pc_t    i_snap_pc,
  input  debug_pkg::cycle_t i_snap_cycles,
  input  debug_pkg::instr_t i_snap_instr,
  output logic              o_tx_valid,
  output debug_pkg::byte_t  o_tx_data,
  input  logic              i_tx_ready,
  output logic              o_done
);

  import debug_pkg::*;

  logic                                 busy;
  logic                                 is_report;  // Else a single ACK byte.
  report_index_t                        index;
  logic                                 last_byte;
  logic [REPORT_BYTES*BYTE_WIDTH-1:0]   report_word;
  byte_t                                report_byte;

  ////////////////////
  // Byte select.
  assign report_word = {i_snap_pc, i_snap_cycles, i_snap_instr};

  // Index 0 is the most significant byte of the report.
  assign report_byte = report_word[(REPORT_BYTES - 1 - int'(index)) * BYTE_WIDTH +: BYTE_WIDTH];

  assign o_tx_valid = busy;
  assign o_tx_data  = is_report ? report_byte : ACK_LOAD;
  assign last_byte  = !is_report || (index == report_index_t'(REPORT_BYTES - 1));

  ////////////////////
  // Transfer control.
  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      busy      <= 1'b0;
      is_report <= 1'b0;
      index     <= '0;
      o_done    <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (busy) begin
        // Index only moves on a completed transfer.
        if (i_tx_ready) begin
          if (last_byte) begin
            busy   <= 1'b0;
            o_done <= 1'b1;
          end else begin
            index <= index + report_index_t'(1);
          end
        end
      end else if (i_send_ack || i_send_report) begin
        busy      <= 1'b1;
        is_report <= i_send_report;
        index     <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: command_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module command_sequencer (
  input  logic             i_clock,
  input  logic             i_reset,
  input  logic             i_rx_valid,
  input  debug_pkg::byte_t i_rx_data,
  output logic             o_rx_ready,
  input  logic             i_soft_reset_ack,
  output logic             o_soft_reset,
  output logic             o_load_byte_valid,
  output debug_pkg::byte_t o_load_byte,
  input  logic             i_load_done,
  output logic             o_run_start,
  output logic             o_run_step,
  input  logic             i_run_stopped,
  input  logic             i_halted,
  output logic             o_send_ack,
  output logic             o_send_report,
  input  logic             i_tx_done,
  output logic             o_count_clear
);

  import debug_pkg::*;

  seq_state_t state;
  seq_state_t state_next;
  logic       rx_fire;      // Byte accepted this cycle.
  logic       start_cmd;
  logic       step_mode;    // Mode of the last run.

  ////////////////////
  // Handshakes and strobes.
  assign o_rx_ready = (state == S_IDLE) || (state == S_WAIT_GO) ||
                      (state == S_LOAD) || (state == S_WAIT_START);
  assign rx_fire    = i_rx_valid && o_rx_ready;

  assign start_cmd  = (state == S_WAIT_START) && rx_fire &&
                      ((i_rx_data == CMD_RUN) || (i_rx_data == CMD_STEP));

  assign o_soft_reset      = (state == S_SOFT_RESET);
  assign o_load_byte_valid = (state == S_LOAD) && rx_fire;
  assign o_load_byte       = i_rx_data;
  assign o_run_start       = start_cmd;
  assign o_run_step        = (i_rx_data == CMD_STEP);  // Qualified by o_run_start.
  assign o_send_ack        = (state == S_SOFT_RESET) && i_soft_reset_ack;
  assign o_send_report     = (state == S_RUN) && i_run_stopped;
  assign o_count_clear     = (state == S_IDLE) && rx_fire && (i_rx_data == CMD_LOAD);

  ////////////////////
  // Next state.
  always_comb begin
    state_next = state;
    case (state)
      S_IDLE: begin
        if (o_count_clear) begin
          state_next = S_SOFT_RESET;
        end
      end
      S_SOFT_RESET: begin
        if (i_soft_reset_ack) begin
          state_next = S_SEND_ACK;
        end
      end
      S_SEND_ACK: begin
        if (i_tx_done) begin
          state_next = S_WAIT_GO;
        end
      end
      S_WAIT_GO: begin
        if (rx_fire && (i_rx_data == CMD_LOAD_GO)) begin
          state_next = S_LOAD;
        end
      end
      S_LOAD: begin
        if (i_load_done) begin
          state_next = S_WAIT_START;
        end
      end
      S_WAIT_START: begin
        if (start_cmd) begin
          state_next = S_RUN;
        end
      end
      S_RUN: begin
        if (i_run_stopped) begin
          state_next = S_REPORT;
        end
      end
      S_REPORT: begin
        // Only a step that did not hit HALT may continue.
        if (i_tx_done) begin
          state_next = (step_mode && !i_halted) ? S_WAIT_START : S_IDLE;
        end
      end
      default: begin
        state_next = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state     <= S_IDLE;
      step_mode <= 1'b0;
    end else begin
      state <= state_next;
      if (start_cmd) begin
        step_mode <= o_run_step;
      end
    end
  end

endmodule

`default_nettype wire

// File: debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module debug_unit (
  input  logic                 i_clock,
  input  logic                 i_reset,
  // Receive link.
  input  logic                 i_rx_valid,
  input  debug_pkg::byte_t     i_rx_data,
  output logic                 o_rx_ready,
  // Transmit link.
  output logic                 o_tx_valid,
  output debug_pkg::byte_t     o_tx_data,
  input  logic                 i_tx_ready,
  // Core soft reset.
  output logic                 o_soft_reset,
  input  logic                 i_soft_reset_ack,
  // Program memory write port.
  output logic                 o_mem_write,
  output debug_pkg::mem_addr_t o_mem_addr,
  output debug_pkg::instr_t    o_mem_data,
  // Core.
  output logic                 o_pc_enable,
  input  debug_pkg::pc_t       i_pc,
  input  debug_pkg::instr_t    i_instruction
);

  import debug_pkg::*;

  logic   load_byte_valid;
  byte_t  load_byte;
  logic   load_done;
  logic   count_clear;
  logic   run_start;
  logic   run_step;
  logic   run_stopped;
  logic   halted;
  logic   send_ack;
  logic   send_report;
  logic   tx_done;
  pc_t    snap_pc;
  cycle_t snap_cycles;
  instr_t snap_instr;

  ////////////////////
  // Control.
  command_sequencer u_sequencer (
    .i_clock           (i_clock),
    .i_reset           (i_reset),
    .i_rx_valid        (i_rx_valid),
    .i_rx_data         (i_rx_data),
    .o_rx_ready        (o_rx_ready),
    .i_soft_reset_ack  (i_soft_reset_ack),
    .o_soft_reset      (o_soft_reset),
    .o_load_byte_valid (load_byte_valid),
    .o_load_byte       (load_byte),
    .i_load_done       (load_done),
    .o_run_start       (run_start),
    .o_run_step        (run_step),
    .i_run_stopped     (run_stopped),
    .i_halted          (halted),
    .o_send_ack        (send_ack),
    .o_send_report     (send_report),
    .i_tx_done         (tx_done),
    .o_count_clear     (count_clear)
  );

  ////////////////////
  // Datapath blocks.
  program_loader u_loader (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_byte_valid (load_byte_valid),
    .i_byte       (load_byte),
    .i_clear      (count_clear),
    .o_done       (load_done),
    .o_mem_write  (o_mem_write),
    .o_mem_addr   (o_mem_addr),
    .o_mem_data   (o_mem_data)
  );

  run_monitor u_monitor (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_start       (run_start),
    .i_step        (run_step),
    .i_clear       (count_clear),  // Cycle count restarts with each load.
    .i_pc          (i_pc),
    .i_instruction (i_instruction),
    .o_pc_enable   (o_pc_enable),
    .o_stopped     (run_stopped),
    .o_halted      (halted),
    .o_snap_pc     (snap_pc),
    .o_snap_cycles (snap_cycles),
    .o_snap_instr  (snap_instr)
  );

  link_transmitter u_transmitter (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_send_ack    (send_ack),
    .i_send_report (send_report),
    .i_snap_pc     (snap_pc),
    .i_snap_cycles (snap_cycles),
    .i_snap_instr  (snap_instr),
    .o_tx_valid    (o_tx_valid),
    .o_tx_data     (o_tx_data),
    .i_tx_ready    (i_tx_ready),
    .o_done        (tx_done)
  );

endmodule

`default_nettype wire

// File: tb_debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_debug_unit;

  import debug_pkg::*;

  localparam int CLOCK_PERIOD  = 4;
  localparam int RESET_CYCLES  = 8;
  localparam int MEM_WORDS     = 1 << MEM_ADDR_WIDTH;
  localparam int NUM_WORDS     = 3;   // Nonzero words before the terminator.
  localparam int ACK_DELAY     = 3;
  localparam int HOLD_BITS     = 3;   // Up to 7 cycles of transmit back-pressure.
  localparam int IGNORE_WINDOW = 6;
  // Budget of each test in clock cycles.
  localparam int LOAD_CYCLES   = 150;
  localparam int REPORT_CYCLES = 100;
  localparam int IGNORE_CYCLES = 20;
  localparam int TEST_CYCLES   = RESET_CYCLES + 2 * LOAD_CYCLES + 5 * REPORT_CYCLES +
                                 7 * IGNORE_CYCLES;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 200;

  logic      clock;
  logic      reset;
  logic      rx_valid;
  byte_t     rx_data;
  logic      rx_ready;
  logic      tx_valid;
  byte_t     tx_data;
  logic      tx_ready;
  logic      soft_reset;
  logic      soft_reset_ack = 1'b0;
  logic      mem_write;
  mem_addr_t mem_addr;
  instr_t    mem_data;
  logic      pc_enable;
  pc_t       core_pc = '0;
  instr_t    instruction;

  instr_t      program_mem [MEM_WORDS];
  logic        word_loaded [MEM_WORDS] = '{default: 1'b0};
  int          ack_count = 0;
  int          soft_reset_cycles = 0;
  int          write_count = 0;
  int          tx_cycles = 0;
  int          enable_cycles = 0;
  logic [31:0] lfsr_state = 32'h358b_2ccd;

  debug_unit uut (
    .i_clock          (clock),
    .i_reset          (reset),
    .i_rx_valid       (rx_valid),
    .i_rx_data        (rx_data),
    .o_rx_ready       (rx_ready),
    .o_tx_valid       (tx_valid),
    .o_tx_data        (tx_data),
    .i_tx_ready       (tx_ready),
    .o_soft_reset     (soft_reset),
    .i_soft_reset_ack (soft_reset_ack),
    .o_mem_write      (mem_write),
    .o_mem_addr       (mem_addr),
    .o_mem_data       (mem_data),
    .o_pc_enable      (pc_enable),
    .i_pc             (core_pc),
    .i_instruction    (instruction)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  ////////////////////
  // Core and memory model.
  assign instruction = word_loaded[core_pc[MEM_ADDR_WIDTH-1:0]] ?
                       program_mem[core_pc[MEM_ADDR_WIDTH-1:0]] : HALT_WORD;

  always @(posedge clock) begin
    if (!reset || soft_reset) begin
      core_pc <= '0;
      for (int a = 0; a < MEM_WORDS; a++) begin
        word_loaded[a] <= 1'b0;  // Unloaded words read as HALT.
      end
    end else begin
      if (pc_enable) begin
        core_pc <= core_pc + pc_t'(1);
      end
      if (mem_write) begin
        program_mem[mem_addr] <= mem_data;
        word_loaded[mem_addr] <= 1'b1;
      end
    end
  end

  // Acknowledge arrives a few cycles into the soft reset.
  always @(posedge clock) begin
    if (soft_reset) begin
      ack_count <= ack_count + 1;
      if (ack_count == ACK_DELAY) begin
        soft_reset_ack <= 1'b1;
      end
    end else begin
      ack_count      <= 0;
      soft_reset_ack <= 1'b0;
    end
  end

  always @(posedge clock) begin
    if (soft_reset) soft_reset_cycles <= soft_reset_cycles + 1;
    if (mem_write) write_count <= write_count + 1;
    if (tx_valid) tx_cycles <= tx_cycles + 1;
    if (pc_enable) enable_cycles <= enable_cycles + 1;
  end

  ////////////////////
  // Helpers.
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic draw_random(input int bits, output int value);
    value = 0;
    for (int i = 0; i < bits; i++) begin
      value = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit.
    end
  endtask

  // Test program, terminated by HALT_WORD.
  function automatic instr_t program_word(input int address);
    case (address)
      0:       return 32'h2008_0005;
      1:       return 32'h2109_0003;
      2:       return 32'h0109_5020;
      default: return HALT_WORD;
    endcase
  endfunction

  task automatic stop_with_failure();
    $display("Checks failed");
    $fatal(1, "Simulation stopped on the first error.");
  endtask

  task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_instr(input string name, input instr_t expected, input instr_t actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_cycles(input string name, input cycle_t expected, input cycle_t actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic send_byte(input byte_t value);
    @(posedge clock);
    rx_valid <= 1'b1;
    rx_data  <= value;
    do begin
      @(negedge clock);
    end while (!rx_ready);
    @(posedge clock);  // Transfer edge.
    rx_valid <= 1'b0;
  endtask

  task automatic receive_byte(output byte_t value);
    int    hold;
    byte_t first;
    draw_random(HOLD_BITS, hold);
    do begin
      @(negedge clock);
    end while (!tx_valid);
    if (rx_ready) begin
      $display("o_rx_ready was high at %0t while a byte was being sent", $time);
      stop_with_failure();
    end
    first = tx_data;
    repeat (hold) begin
      @(negedge clock);
      if (!tx_valid) begin
        $display("o_tx_valid dropped at %0t before the byte was taken", $time);
        stop_with_failure();
      end
      check_byte("o_tx_data under back-pressure", first, tx_data);
    end
    @(posedge clock);
    tx_ready <= 1'b1;
    @(negedge clock);
    check_byte("o_tx_data at transfer", first, tx_data);
    value = first;
    @(posedge clock);
    tx_ready <= 1'b0;
  endtask

  task automatic expect_report(input pc_t pc, input cycle_t cycles, input instr_t instr);
    logic [REPORT_BYTES*BYTE_WIDTH-1:0] report;
    byte_t                              value;
    report = '0;
    for (int i = 0; i < REPORT_BYTES; i++) begin
      receive_byte(value);
      report = {report[(REPORT_BYTES-1)*BYTE_WIDTH-1:0], value};  // MSB first.
    end
    check_pc("report PC", pc, report[REPORT_BYTES*BYTE_WIDTH-1 -: PC_WIDTH]);
    check_cycles("report cycle count", cycles, report[INSTR_WIDTH +: CYCLE_WIDTH]);
    check_instr("report instruction", instr, report[INSTR_WIDTH-1:0]);
  endtask

  ////////////////////
  // Tests.
  task automatic send_ignored_byte(input byte_t value);
    int soft_before;
    int writes_before;
    int tx_before;
    int enable_before;
    @(negedge clock);
    soft_before   = soft_reset_cycles;
    writes_before = write_count;
    tx_before     = tx_cycles;
    enable_before = enable_cycles;
    send_byte(value);
    repeat (IGNORE_WINDOW) @(negedge clock);
    if (soft_reset_cycles != soft_before || write_count != writes_before ||
        tx_cycles != tx_before || enable_cycles != enable_before) begin
      $display("Byte %h should have been ignored but caused activity", value);
      stop_with_failure();
    end
  endtask

  task automatic load_handshake();
    byte_t ack;
    send_byte(CMD_LOAD);
    @(negedge clock);
    if (!soft_reset) begin
      $display("o_soft_reset did not rise the cycle after CMD_LOAD");
      stop_with_failure();
    end
    if (rx_ready) begin
      $display("o_rx_ready was high during the soft reset");
      stop_with_failure();
    end
    do begin
      @(negedge clock);
    end while (!soft_reset_ack);
    @(negedge clock);
    if (soft_reset || !tx_valid) begin
      $display("o_soft_reset did not fall together with the load acknowledge");
      stop_with_failure();
    end
    receive_byte(ack);
    check_byte("o_tx_data load acknowledge", ACK_LOAD, ack);
  endtask

  task automatic load_program();
    int     writes_before;
    instr_t word;
    @(negedge clock);
    writes_before = write_count;
    send_byte(CMD_LOAD_GO);
    for (int w = 0; w <= NUM_WORDS; w++) begin
      word = program_word(w);
      for (int b = BYTES_PER_INSTR - 1; b >= 0; b--) begin
        send_byte(word[b*BYTE_WIDTH +: BYTE_WIDTH]);
      end
    end
    repeat (2) @(negedge clock);
    if (write_count - writes_before != NUM_WORDS || word_loaded[NUM_WORDS]) begin
      $display("Program load wrote %0d words, the zero word must not be written",
               write_count - writes_before);
      stop_with_failure();
    end
    for (int w = 0; w < NUM_WORDS; w++) begin
      check_instr("program memory word", program_word(w), program_mem[w]);
    end
  endtask

  task automatic continuous_run();
    send_byte(CMD_RUN);
    expect_report(pc_t'(NUM_WORDS), cycle_t'(NUM_WORDS), HALT_WORD);
  endtask

  task automatic step_run();
    for (int step = 1; step <= NUM_WORDS; step++) begin
      send_byte(CMD_STEP);
      expect_report(pc_t'(step), cycle_t'(step), program_word(step));
    end
    // Step at the HALT word leaves PC and count alone.
    send_byte(CMD_STEP);
    expect_report(pc_t'(NUM_WORDS), cycle_t'(NUM_WORDS), HALT_WORD);
    send_ignored_byte(CMD_RUN);  // Back in idle.
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    stop_with_failure();
  end

  initial begin
    reset    <= 1'b0;
    rx_valid <= 1'b0;
    rx_data  <= '0;
    tx_ready <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b1;

    send_ignored_byte(CMD_RUN);
    send_ignored_byte(CMD_STEP);
    send_ignored_byte(8'h5a);
    load_handshake();
    load_program();
    send_ignored_byte(CMD_LOAD);
    send_ignored_byte(CMD_LOAD_GO);
    send_ignored_byte(8'hc3);
    continuous_run();
    load_handshake();
    load_program();
    step_run();

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
debug_pkg.sv
program_loader.sv
run_monitor.sv
link_transmitter.sv
command_sequencer.sv
debug_unit.sv
tb_debug_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build the debug unit testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"
verilator --binary --top-module tb_debug_unit -f filelist.f -o tb_debug_unit
./obj_dir/tb_debug_unit
